// File: run.sh
#!/usr/bin/env bash
# Builds the trap path testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module trapUnit_tb \
   --Mdir obj_dir -f verilog.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/VtrapUnit_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if grep -qx "Testbench passed" sim.log; then
   exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: tests/trapRef.svh
`ifndef TRAP_REF_SVH
`define TRAP_REF_SVH

// Expected trap for one instruction. The first matching rule wins.
function automatic void refTrap(
   input  logic           jump,
   input  logic [31:0]    jumpDst,
   input  logic [31:0]    instPc,
   input  logic [31:0]    addr,
   input  mem_inst_type_t memType,
   input  logic           invalid,
   input  logic           isPriv,
   input  logic [31:0]    privCode,
   input  logic           timer,
   output logic           present,
   output logic [31:0]    cause,
   output logic [31:0]    info
);
   logic [31:0] ramLast;
   logic [31:0] size;
   logic        store;
   logic        allowed;
   ramLast = PC_VALID_RANGE_BASE + ((32'd1 << RAM_WIDTH) - 32'd1);
   store   = (memType == MEM_SB) || (memType == MEM_SH) || (memType == MEM_SW);
   allowed = ((addr >= PC_VALID_RANGE_BASE) && (addr <= ramLast)) || (addr == CONSOLE_ADDRESS)
             || ((addr >= MTIME_MEM_ADDRESS_LOW) && (addr <= MTIMECMP_MEM_ADDRESS_HIGH));
   case (memType)
      MEM_LH, MEM_LHU, MEM_SH: size = 32'd2;
      MEM_LW, MEM_SW:          size = 32'd4;
      default:                 size = 32'd1;   // Bytes and no access never misalign.
   endcase
   present = 1'b1;
   cause   = 32'd0;
   info    = 32'd0;
   if (jump && ((jumpDst % 32'd4) != 32'd0)) begin
      cause = M_INSTR_MISALIGN;
      info  = jumpDst;
   end else if ((instPc < PC_VALID_RANGE_BASE) || (instPc > ramLast)) begin
      cause = M_INSTR_AFAULT;
      info  = instPc;
   end else if (invalid) begin
      cause = M_ILL_INSTR;
      info  = instPc;
   end else if (isPriv) begin
      cause = privCode;
      info  = instPc;
   end else if ((memType != MEM_NONE) && !allowed) begin
      cause = store ? M_STORE_AFAULT : M_LOAD_AFAULT;
      info  = addr;
   end else if ((addr % size) != 32'd0) begin
      cause = store ? M_STORE_MISALIGN : M_LOAD_MISALIGN;
      info  = addr;
   end else if (timer) begin
      cause = M_TIMER_INT;
   end else begin
      present = 1'b0;
   end
endfunction

`endif

// File: tests/trapUnit_tb.sv
`timescale 1ns/10ps

module trapUnit_tb;

   import Common::*;

   `include "trapRef.svh"

   localparam int PULSE_TIMEOUT = 4;

   typedef struct packed {
      logic [31:0] cause;
      logic [31:0] info;
      logic [31:0] pc;
      logic [31:0] redirect;
      int          edgeNo;
   } expTrap_t;

   logic clk, arstN, instValid, stall, shouldJump, instInvalid, priv, mtimeExc, mtvecWe;
   logic [31:0] pcJumpDst, pc, dataAddress, privCause, mtvecData;
   mem_inst_type_t memInstType;
   logic trapTaken;
   logic [31:0] redirectPc, mcause, mtval, mepc;

   // Next instruction, staged before it is driven.
   logic sValid, sJump, sInvalid, sPriv, sTimer;
   logic [31:0] sJumpDst, sPc, sAddr, sPrivCause;
   mem_inst_type_t sMem;

   // Expected state of the trap path.
   logic mRecValid;
   logic [31:0] mRecCause, mRecInfo, mRecPc, mMtvec;
   string mRecName, curName;

   expTrap_t expQ[$];
   string nameQ[$];
   int edgeCnt = 0, errors = 0, checks = 0, pulses = 0, lastPulseEdge = 0, lastIssueEdge = 0;

   trapUnit uut (
      .clk_i(clk), .arstN_i(arstN), .instValid_i(instValid), .stall_i(stall),
      .shouldJump_i(shouldJump), .pcJumpDst_i(pcJumpDst), .pc_i(pc),
      .dataAddress_i(dataAddress), .memInstType_i(memInstType), .instInvalid_i(instInvalid),
      .priv_i(priv), .privCause_i(privCause), .mtimeExc_i(mtimeExc), .mtvecWe_i(mtvecWe),
      .mtvecData_i(mtvecData), .trapTaken_o(trapTaken), .redirectPc_o(redirectPc),
      .mcause_o(mcause), .mtval_o(mtval), .mepc_o(mepc)
   );

   initial begin : clockGen
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // ------------------------------------------------------------------------
   // Expected pipeline that advances with the inputs of the cycle that just ended
   // ------------------------------------------------------------------------

   task automatic advanceModel();
      logic        present;
      logic [31:0] cause;
      logic [31:0] info;
      expTrap_t    rec;
      if (mRecValid && !stall) begin
         rec.cause    = mRecCause;
         rec.info     = mRecCause[31] ? 32'd0 : mRecInfo;   // Interrupts clear mtval.
         rec.pc       = mRecPc;
         rec.redirect = mMtvec & 32'hFFFF_FFFC;
         rec.edgeNo   = edgeCnt;
         expQ.push_back(rec);
         nameQ.push_back(mRecName);
      end
      if (mtvecWe) mMtvec = mtvecData;               // Old base already used above.
      if (!stall) begin
         refTrap(shouldJump, pcJumpDst, pc, dataAddress, memInstType, instInvalid, priv,
                 privCause, mtimeExc, present, cause, info);
         if (instValid && present && !mRecValid) begin
            mRecCause = cause;
            mRecInfo  = info;
            mRecPc    = pc;
            mRecName  = curName;
            mRecValid = 1'b1;
         end else begin
            mRecValid = 1'b0;                          // Also kills the younger instruction.
         end
      end
   endtask

   task automatic tick();
      @(posedge clk);
      edgeCnt++;
      advanceModel();
   endtask

   task automatic stageDefaults();
      sValid     = 1'b1;
      sJump      = 1'b0;
      sInvalid   = 1'b0;
      sPriv      = 1'b0;
      sTimer     = 1'b0;
      sJumpDst   = PC_VALID_RANGE_BASE + 32'h100;
      sPc        = PC_VALID_RANGE_BASE + 32'h40;
      sAddr      = PC_VALID_RANGE_BASE + 32'h200;
      sPrivCause = 32'd0;
      sMem       = MEM_NONE;
   endtask

   task automatic issue(input string name);
      tick();
      curName       = name;
      lastIssueEdge = edgeCnt;
      instValid   <= sValid;
      stall       <= 1'b0;
      mtvecWe     <= 1'b0;
      shouldJump  <= sJump;
      pcJumpDst   <= sJumpDst;
      pc          <= sPc;
      dataAddress <= sAddr;
      memInstType <= sMem;
      instInvalid <= sInvalid;
      priv        <= sPriv;
      privCause   <= sPrivCause;
      mtimeExc    <= sTimer;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         tick();
         instValid <= 1'b0;
         stall     <= 1'b0;
         mtvecWe   <= 1'b0;
      end
   endtask

   task automatic hold(input int n);
      repeat (n) begin
         tick();
         stall   <= 1'b1;
         mtvecWe <= 1'b0;
      end
   endtask

   task automatic writeMtvec(input logic [31:0] data);
      tick();
      instValid <= 1'b0;
      stall     <= 1'b0;
      mtvecWe   <= 1'b1;
      mtvecData <= data;
   endtask

   task automatic runCase(input string name);
      issue(name);
      idle(3);
   endtask

   function automatic logic [31:0] pickAddr(input int unsigned kind);
      case (kind)
         0: return PC_VALID_RANGE_BASE | ($urandom & 32'h0000_FFFF);
         1: return CONSOLE_ADDRESS;
         2: return MTIME_MEM_ADDRESS_LOW + ($urandom % 16);
         3: return 32'h4000_0000 | ($urandom & 32'h00FF_FFFF);
         default: return MTIMECMP_MEM_ADDRESS_HIGH + 32'd1;  // Just past the timer window.
      endcase
   endfunction

   // ------------------------------------------------------------------------
   // Compare each trap pulse with the oldest expected record
   // ------------------------------------------------------------------------

   initial begin : compareProc
      expTrap_t want;
      string    name;
      forever begin
         @(negedge clk);
         if (trapTaken) begin
            pulses++;
            lastPulseEdge = edgeCnt;
            if (expQ.size() == 0) begin
               errors++;
               $display("A trap pulse after edge %0d was not expected", edgeCnt);
            end else begin
               want = expQ.pop_front();
               name = nameQ.pop_front();
               checks++;
               if (edgeCnt != want.edgeNo) begin
                  errors++;
                  $display("Fail %s: pulse edge expected %0d actual %0d", name, want.edgeNo,
                           edgeCnt);
               end
               if (mcause !== want.cause) begin
                  errors++;
                  $display("Fail %s: mcause expected %h actual %h", name, want.cause, mcause);
               end
               if (mtval !== want.info) begin
                  errors++;
                  $display("Fail %s: mtval expected %h actual %h", name, want.info, mtval);
               end
               if (mepc !== want.pc) begin
                  errors++;
                  $display("Fail %s: mepc expected %h actual %h", name, want.pc, mepc);
               end
               if (redirectPc !== want.redirect) begin
                  errors++;
                  $display("Fail %s: redirect expected %h actual %h", name, want.redirect,
                           redirectPc);
               end
            end
         end else if ((expQ.size() > 0) && (edgeCnt > expQ[0].edgeNo + PULSE_TIMEOUT)) begin
            errors++;
            want = expQ.pop_front();
            name = nameQ.pop_front();
            $display("%s: the expected trap pulse never arrived", name);
         end
      end
   end

   initial begin : stimulusProc
      int          issueEdge;
      int          pulsesBefore;
      int          waitCnt;
      void'($urandom(32'hf302cf36));
      arstN       <= 1'b0;
      instValid   <= 1'b0;
      stall       <= 1'b0;
      shouldJump  <= 1'b0;
      pcJumpDst   <= 32'd0;
      pc          <= 32'd0;
      dataAddress <= 32'd0;
      memInstType <= MEM_NONE;
      instInvalid <= 1'b0;
      priv        <= 1'b0;
      privCause   <= 32'd0;
      mtimeExc    <= 1'b0;
      mtvecWe     <= 1'b0;
      mtvecData   <= 32'd0;
      mRecValid = 1'b0;
      mMtvec    = MTVEC_RESET;
      curName   = "";
      repeat (3) @(posedge clk);
      arstN <= 1'b1;
      @(negedge clk);
      if (mcause !== 32'd0) begin
         errors++;
         $display("Fail reset: mcause expected %h actual %h", 32'd0, mcause);
      end
      if (mtval !== 32'd0) begin
         errors++;
         $display("Fail reset: mtval expected %h actual %h", 32'd0, mtval);
      end
      if (mepc !== 32'd0) begin
         errors++;
         $display("Fail reset: mepc expected %h actual %h", 32'd0, mepc);
      end

      stageDefaults();
      runCase("clean alu");
      stageDefaults();
      sMem  = MEM_LW;
      sAddr = PC_VALID_RANGE_BASE + 32'h400;
      runCase("clean lw");
      stageDefaults();
      sMem  = MEM_SB;
      sAddr = PC_VALID_RANGE_BASE + 32'h401;
      runCase("clean sb");

      stageDefaults();
      sJump    = 1'b1;
      sJumpDst = PC_VALID_RANGE_BASE + 32'h102;
      runCase("jump misalign");
      stageDefaults();
      sPc = 32'h0001_0040;
      runCase("pc outside ram");
      stageDefaults();
      sInvalid = 1'b1;
      runCase("illegal");
      stageDefaults();
      sPriv      = 1'b1;
      sPrivCause = 32'd11;
      runCase("privileged");
      stageDefaults();
      sPriv      = 1'b1;
      sPrivCause = 32'h8000_0003;
      runCase("privileged interrupt");
      stageDefaults();
      sMem  = MEM_LW;
      sAddr = 32'h4000_0000;
      runCase("load fault");
      stageDefaults();
      sMem  = MEM_SB;
      sAddr = 32'h0000_0210;
      runCase("store fault");
      for (int t = 1; t <= 8; t++) begin
         for (int off = 1; off <= 3; off++) begin
            stageDefaults();
            sMem  = mem_inst_type_t'(4'(t));
            sAddr = PC_VALID_RANGE_BASE + 32'h300 + 32'(off);
            runCase($sformatf("misalign type %0d offset %0d", t, off));
         end
      end
      stageDefaults();
      sMem  = MEM_SW;
      sAddr = CONSOLE_ADDRESS;
      runCase("console");
      stageDefaults();
      sMem  = MEM_LW;
      sAddr = MTIME_MEM_ADDRESS_LOW + 32'd4;
      runCase("mtime");
      stageDefaults();
      sMem  = MEM_SW;
      sAddr = MTIMECMP_MEM_ADDRESS_HIGH - 32'd3;
      runCase("mtimecmp");
      stageDefaults();
      sTimer = 1'b1;
      runCase("timer");

      stageDefaults();
      sInvalid = 1'b1;
      issue("timing no stall");
      issueEdge = lastIssueEdge;
      idle(4);
      @(negedge clk);
      if (lastPulseEdge != issueEdge + 2) begin
         errors++;
         $display("Fail timing no stall: edge expected %0d actual %0d", issueEdge + 2,
                  lastPulseEdge);
      end
      stageDefaults();
      sInvalid = 1'b1;
      issue("timing stall");
      issueEdge = lastIssueEdge;
      hold(3);
      idle(4);
      @(negedge clk);
      if (lastPulseEdge != issueEdge + 5) begin
         errors++;
         $display("Fail timing stall: edge expected %0d actual %0d", issueEdge + 5,
                  lastPulseEdge);
      end

      pulsesBefore = pulses;
      stageDefaults();
      sInvalid = 1'b1;
      issue("shadow first");
      stageDefaults();
      sPc = 32'h0003_0000;
      issue("shadow second");
      idle(4);
      if (pulses - pulsesBefore != 1) begin
         errors++;
         $display("Fail shadow kill: pulses expected %0d actual %0d", 1, pulses - pulsesBefore);
      end

      writeMtvec(32'h8000_0A03);
      stageDefaults();
      sInvalid = 1'b1;
      issue("mtvec new base");
      idle(4);
      @(negedge clk);
      if (redirectPc !== 32'h8000_0A00) begin
         errors++;
         $display("Fail mtvec new base: expected %h actual %h", 32'h8000_0A00, redirectPc);
      end
      stageDefaults();
      sInvalid = 1'b1;
      issue("mtvec same edge");
      writeMtvec(32'h8000_0C01);                      // Lands on the commit edge.
      idle(3);
      @(negedge clk);
      if (redirectPc !== 32'h8000_0A00) begin
         errors++;
         $display("Fail mtvec same edge: expected %h actual %h", 32'h8000_0A00, redirectPc);
      end
      stageDefaults();
      sTimer = 1'b1;
      issue("mtvec after write");
      idle(4);
      @(negedge clk);
      if (redirectPc !== 32'h8000_0C00) begin
         errors++;
         $display("Fail mtvec after write: expected %h actual %h", 32'h8000_0C00, redirectPc);
      end

      for (int i = 0; i < 80; i++) begin
         stageDefaults();
         sValid     = ($urandom % 8) != 0;
         sJump      = ($urandom % 4) == 0;
         sJumpDst   = PC_VALID_RANGE_BASE | ($urandom & 32'h0000_00FF);
         sPc        = (($urandom % 6) == 0) ? 32'h0002_0000 | ($urandom & 32'h0000_FFFC)
                                            : PC_VALID_RANGE_BASE | ($urandom & 32'h0000_FFFC);
         sInvalid   = ($urandom % 6) == 0;
         sPriv      = ($urandom % 6) == 0;
         sPrivCause = (($urandom % 2) == 0) ? 32'd3 : 32'd11;
         sMem       = mem_inst_type_t'(4'($urandom % 9));
         sAddr      = pickAddr($urandom % 5);
         sTimer     = ($urandom % 5) == 0;
         issue($sformatf("random %0d", i));
         if (($urandom % 4) == 0) hold(1 + $urandom % 2);
         idle($urandom % 3);
      end

      waitCnt = 0;
      while ((expQ.size() > 0) && (waitCnt < 20)) begin
         idle(1);
         waitCnt++;
      end
      if (expQ.size() > 0) begin
         errors++;
         $display("Expected trap pulses were still pending at the end of the run");
      end
      idle(2);
      $display("Checks: %0d, pulses: %0d, errors: %0d", checks, pulses, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: verilog.f
+incdir+tests
verilog/Common.sv
verilog/excDetect.sv
verilog/trapReg.sv
verilog/trapCsr.sv
verilog/trapUnit.sv
tests/trapUnit_tb.sv

// File: verilog/Common.sv
package Common;

   // ------------------------------------------------------------------------
   // Memory access type of the instruction in execute
   // ------------------------------------------------------------------------

   typedef enum logic [3:0] {
      MEM_NONE = 4'd0,                          // No memory access.
      MEM_LB,
      MEM_LH,
      MEM_LW,
      MEM_LBU,
      MEM_LHU,
      MEM_SB,
      MEM_SH,
      MEM_SW
   } mem_inst_type_t;

   // ------------------------------------------------------------------------
   // Machine mode cause codes
   // ------------------------------------------------------------------------

   localparam logic [31:0] M_INSTR_MISALIGN  = 32'd0;
   localparam logic [31:0] M_INSTR_AFAULT    = 32'd1;
   localparam logic [31:0] M_ILL_INSTR       = 32'd2;
   localparam logic [31:0] M_LOAD_MISALIGN   = 32'd4;
   localparam logic [31:0] M_LOAD_AFAULT     = 32'd5;
   localparam logic [31:0] M_STORE_MISALIGN  = 32'd6;
   localparam logic [31:0] M_STORE_AFAULT    = 32'd7;
   localparam logic [31:0] M_TIMER_INT       = 32'h8000_0007;   // Interrupt bit set.

   // ------------------------------------------------------------------------
   // Address map
   // ------------------------------------------------------------------------

   // Low address bits that index into RAM.
   localparam int          RAM_WIDTH                  = 16;
   localparam logic [31:0] PC_VALID_RANGE_BASE        = 32'h8000_0000;

   // The timer register window includes both of its bounds.
   localparam logic [31:0] MTIME_MEM_ADDRESS_LOW      = 32'h0000_0200;
   localparam logic [31:0] MTIMECMP_MEM_ADDRESS_HIGH  = 32'h0000_020F;

   localparam logic [31:0] CONSOLE_ADDRESS            = 32'h0000_0100;

   // ------------------------------------------------------------------------
   // Trap CSR reset values
   // ------------------------------------------------------------------------

   localparam logic [31:0] MTVEC_RESET                = 32'h8000_0100;

endpackage

// File: verilog/excDetect.sv
`timescale 1ns/10ps

module excDetect (
   input  logic                   shouldJump_i,
   input  logic [31:0]            pcJumpDst_i,
   input  logic [31:0]            pc_i,
   input  logic [31:0]            dataAddress_i,
   input  Common::mem_inst_type_t memInstType_i,
   input  logic                   instInvalid_i,
   input  logic                   priv_i,
   input  logic [31:0]            privCause_i,
   input  logic                   mtimeExc_i,
   output logic [31:0]            excCause_o,
   output logic [31:0]            trapInfo_o,
   output logic                   excPresent_o
);

   import Common::*;

   logic        jumpMisalign;
   logic        pcOutside;
   logic        dataInRam;
   logic        dataInTimer;
   logic        dataAllowed;
   logic        accessFault;
   logic        dataMisalign;
   logic        isLoad;
   logic        isStore;
   logic        halfAccess;
   logic        wordAccess;

   logic        excPresent;
   logic [31:0] excCause;
   logic [31:0] trapInfo;

   assign excPresent_o = excPresent;
   assign excCause_o   = excCause;
   assign trapInfo_o   = trapInfo;

   // ------------------------------------------------------------------------
   // Individual fault conditions
   // ------------------------------------------------------------------------

   assign jumpMisalign = shouldJump_i && (pcJumpDst_i[1:0] != 2'b00);
   assign pcOutside    = pc_i[31:RAM_WIDTH] != PC_VALID_RANGE_BASE[31:RAM_WIDTH];

   assign dataInRam    = dataAddress_i[31:RAM_WIDTH] == PC_VALID_RANGE_BASE[31:RAM_WIDTH];
   assign dataInTimer  = (dataAddress_i >= MTIME_MEM_ADDRESS_LOW)
                         && (dataAddress_i <= MTIMECMP_MEM_ADDRESS_HIGH);
   assign dataAllowed  = (dataAddress_i == CONSOLE_ADDRESS) || dataInRam || dataInTimer;
   assign accessFault  = (|memInstType_i) && !dataAllowed;

   always_comb begin
      isLoad     = 1'b0;
      isStore    = 1'b0;
      halfAccess = 1'b0;
      wordAccess = 1'b0;
      unique case (memInstType_i)
         MEM_LB, MEM_LBU: isLoad = 1'b1;
         MEM_LH, MEM_LHU: begin
            isLoad     = 1'b1;
            halfAccess = 1'b1;
         end
         MEM_LW: begin
            isLoad     = 1'b1;
            wordAccess = 1'b1;
         end
         MEM_SB: isStore = 1'b1;
         MEM_SH: begin
            isStore    = 1'b1;
            halfAccess = 1'b1;
         end
         MEM_SW: begin
            isStore    = 1'b1;
            wordAccess = 1'b1;
         end
         default: begin
         end
      endcase
   end

   // Halfwords need bit 0 clear, words need both low bits clear.
   assign dataMisalign = (halfAccess && dataAddress_i[0])
                         || (wordAccess && (dataAddress_i[1:0] != 2'b00));

   // ------------------------------------------------------------------------
   // Priority selection where the first match wins
   // ------------------------------------------------------------------------

   always_comb begin
      excPresent = 1'b0;
      excCause   = '0;
      trapInfo   = '0;
      if (jumpMisalign) begin
         excPresent = 1'b1;
         excCause   = M_INSTR_MISALIGN;
         trapInfo   = pcJumpDst_i;
      end else if (pcOutside) begin
         excPresent = 1'b1;
         excCause   = M_INSTR_AFAULT;
         trapInfo   = pc_i;
      end else if (instInvalid_i) begin
         excPresent = 1'b1;
         excCause   = M_ILL_INSTR;
         trapInfo   = pc_i;
      end else if (priv_i) begin
         excPresent = 1'b1;
         excCause   = privCause_i;                 // Cause comes from the decoder.
         trapInfo   = pc_i;
      end else if (accessFault) begin
         excPresent = 1'b1;
         excCause   = isStore ? M_STORE_AFAULT : M_LOAD_AFAULT;
         trapInfo   = dataAddress_i;
      end else if (dataMisalign) begin
         excPresent = 1'b1;
         excCause   = isLoad ? M_LOAD_MISALIGN : M_STORE_MISALIGN;
         trapInfo   = dataAddress_i;
      end else if (mtimeExc_i) begin
         excPresent = 1'b1;
         excCause   = M_TIMER_INT;                 // Interrupts carry no trap value.
      end
   end

   // A reported exception must carry a known cause into the trap CSRs.
   always_comb begin
      if (excPresent_o) begin
         assert (!$isunknown(excCause_o))
            else $error("excDetect: exception reported with unknown cause");
      end
   end

endmodule

// File: verilog/trapCsr.sv
`timescale 1ns/10ps

module trapCsr (
   input  logic        clk_i,
   input  logic        arstN_i,
   input  logic        stall_i,
   input  logic        recValid_i,
   input  logic [31:0] recCause_i,
   input  logic [31:0] recInfo_i,
   input  logic [31:0] recPc_i,
   input  logic        mtvecWe_i,
   input  logic [31:0] mtvecData_i,
   output logic        trapTaken_o,
   output logic [31:0] redirectPc_o,
   output logic [31:0] mcause_o,
   output logic [31:0] mtval_o,
   output logic [31:0] mepc_o
);

   import Common::*;

   logic        commit;
   logic        isInterrupt;
   logic        trapTaken;
   logic [31:0] redirectPc;
   logic [31:0] mcause;
   logic [31:0] mtval;
   logic [31:0] mepc;
   logic [31:0] mtvec;

   assign trapTaken_o  = trapTaken;
   assign redirectPc_o = redirectPc;
   assign mcause_o     = mcause;
   assign mtval_o      = mtval;
   assign mepc_o       = mepc;

   assign commit      = recValid_i && !stall_i;
   assign isInterrupt = recCause_i[31];

   // ------------------------------------------------------------------------
   // Trap commit
   // ------------------------------------------------------------------------

   always_ff @(posedge clk_i or negedge arstN_i) begin
      if (!arstN_i) begin
         trapTaken  <= 1'b0;
         redirectPc <= '0;
         mcause     <= '0;
         mtval      <= '0;
         mepc       <= '0;
      end else begin
         trapTaken <= commit;                      // One cycle per commit.
         if (commit) begin
            mcause     <= recCause_i;
            mtval      <= isInterrupt ? 32'd0 : recInfo_i;
            mepc       <= recPc_i;
            redirectPc <= {mtvec[31:2], 2'b00};    // Direct mode only.
         end
      end
   end

   // ------------------------------------------------------------------------
   // Trap vector base
   // ------------------------------------------------------------------------

   // A write on the commit edge lands after the redirect has sampled the old base.
   always_ff @(posedge clk_i or negedge arstN_i) begin
      if (!arstN_i) begin
         mtvec <= MTVEC_RESET;
      end else if (mtvecWe_i) begin
         mtvec <= mtvecData_i;
      end
   end

   // Back to back pulses would mean the buffer handed one record over twice.
   assert property (@(posedge clk_i) disable iff (!arstN_i)
                    trapTaken_o |=> !trapTaken_o)
      else $error("trapCsr: trap pulse longer than one cycle");

endmodule

// File: verilog/trapReg.sv
`timescale 1ns/10ps

module trapReg (
   input  logic        clk_i,
   input  logic        arstN_i,
   input  logic        instValid_i,
   input  logic        stall_i,
   input  logic        excPresent_i,
   input  logic [31:0] excCause_i,
   input  logic [31:0] trapInfo_i,
   input  logic [31:0] pc_i,
   output logic        recValid_o,
   output logic [31:0] recCause_o,
   output logic [31:0] recInfo_o,
   output logic [31:0] recPc_o
);

   logic        recValid;
   logic        capture;
   logic [31:0] recCause;
   logic [31:0] recInfo;
   logic [31:0] recPc;

   assign recValid_o = recValid;
   assign recCause_o = recCause;
   assign recInfo_o  = recInfo;
   assign recPc_o    = recPc;

   // The instruction right behind a buffered trap is flushed, so it never captures.
   assign capture = instValid_i && excPresent_i && !recValid;

   always_ff @(posedge clk_i or negedge arstN_i) begin
      if (!arstN_i) begin
         recValid <= 1'b0;
      end else if (!stall_i) begin
         recValid <= capture;                      // Drops after one free cycle.
      end
   end

   always_ff @(posedge clk_i) begin
      if (!stall_i && capture) begin
         recCause <= excCause_i;
         recInfo  <= trapInfo_i;
         recPc    <= pc_i;                         // Becomes mepc.
      end
   end

   // ------------------------------------------------------------------------
   // A record is handed over exactly once, so it may not survive a free edge.
   // ------------------------------------------------------------------------

   assert property (@(posedge clk_i) disable iff (!arstN_i)
                    (recValid_o && !stall_i) |=> !recValid_o)
      else $error("trapReg: record held across an unstalled edge");

endmodule

// File: verilog/trapUnit.sv
`timescale 1ns/10ps

module trapUnit (
   input  logic                   clk_i,
   input  logic                   arstN_i,
   input  logic                   instValid_i,
   input  logic                   stall_i,
   input  logic                   shouldJump_i,
   input  logic [31:0]            pcJumpDst_i,
   input  logic [31:0]            pc_i,
   input  logic [31:0]            dataAddress_i,
   input  Common::mem_inst_type_t memInstType_i,
   input  logic                   instInvalid_i,
   input  logic                   priv_i,
   input  logic [31:0]            privCause_i,
   input  logic                   mtimeExc_i,
   input  logic                   mtvecWe_i,
   input  logic [31:0]            mtvecData_i,
   output logic                   trapTaken_o,
   output logic [31:0]            redirectPc_o,
   output logic [31:0]            mcause_o,
   output logic [31:0]            mtval_o,
   output logic [31:0]            mepc_o
);

   logic        excPresent;
   logic [31:0] excCause;
   logic [31:0] trapInfo;
   logic        recValid;
   logic [31:0] recCause;
   logic [31:0] recInfo;
   logic [31:0] recPc;

   excDetect excDetect_i (
      .shouldJump_i  (shouldJump_i),
      .pcJumpDst_i   (pcJumpDst_i),
      .pc_i          (pc_i),
      .dataAddress_i (dataAddress_i),
      .memInstType_i (memInstType_i),
      .instInvalid_i (instInvalid_i),
      .priv_i        (priv_i),
      .privCause_i   (privCause_i),
      .mtimeExc_i    (mtimeExc_i),
      .excCause_o    (excCause),
      .trapInfo_o    (trapInfo),
      .excPresent_o  (excPresent)
   );

   trapReg trapReg_i (
      .clk_i        (clk_i),
      .arstN_i      (arstN_i),
      .instValid_i  (instValid_i),
      .stall_i      (stall_i),
      .excPresent_i (excPresent),
      .excCause_i   (excCause),
      .trapInfo_i   (trapInfo),
      .pc_i         (pc_i),
      .recValid_o   (recValid),
      .recCause_o   (recCause),
      .recInfo_o    (recInfo),
      .recPc_o      (recPc)
   );

   trapCsr trapCsr_i (
      .clk_i        (clk_i),
      .arstN_i      (arstN_i),
      .stall_i      (stall_i),
      .recValid_i   (recValid),
      .recCause_i   (recCause),
      .recInfo_i    (recInfo),
      .recPc_i      (recPc),
      .mtvecWe_i    (mtvecWe_i),
      .mtvecData_i  (mtvecData_i),
      .trapTaken_o  (trapTaken_o),
      .redirectPc_o (redirectPc_o),
      .mcause_o     (mcause_o),
      .mtval_o      (mtval_o),
      .mepc_o       (mepc_o)
   );

endmodule
